/* fetchInput.txt */
// Header: program word count, cycle count. Program lines: byte address, instruction word
// Cycle lines: test pcSel rs imm brnchAddr, then expected pc instrC writeRegAddr halt ctrlErr flags
// flags = regWrite memEnable memWr bFlag; tests 1 load, 2 decode, 3 redirect, 4 load-use, 5 halt
0010 0016
0000 0800
0002 2002
0004 4145
0006 C312
0008 D954
000A 8461
000C 1800
000E 3004
0010 6206
0020 2904
0034 1000
0040 8961
0042 D879
0044 8C40
0046 41A1
0048 0000
1 0 0000 0000 0000 0000 0800 0 0 0 0
1 0 0000 0000 0000 0002 2002 0 0 0 0
2 0 0000 0000 0000 0004 4145 2 0 0 8
2 0 0000 0000 0000 0006 C312 3 0 0 8
2 0 0000 0000 0000 0008 D954 5 0 0 8
2 0 0000 0000 0000 000A 8461 4 0 0 6
2 0 0000 0000 0000 000C 1800 0 0 1 0
2 0 0000 0000 0000 000E 3004 7 0 0 8
3 1 0000 0000 0020 0010 6206 2 0 0 1
3 1 0030 0004 0000 0020 2904 1 0 0 0
3 1 0000 0000 0010 0034 1000 0 0 0 0
3 1 0000 0000 0040 0002 2002 0 0 0 0
4 0 0000 0000 0000 0040 8961 3 0 0 C
4 0 0000 0000 0000 0042 0800 0 0 0 0
4 0 0000 0000 0000 0042 D879 6 0 0 8
4 0 0000 0000 0000 0044 8C40 2 0 0 C
4 0 0000 0000 0000 0046 41A1 5 0 0 8
5 0 0000 0000 0000 0048 0000 0 1 0 0
5 1 0000 0000 0010 0048 0000 0 1 0 0
5 0 0000 0000 0000 0048 0000 0 1 0 0
5 1 0004 0002 0000 0048 0000 0 1 0 0
5 0 0000 0000 0000 0048 0000 0 1 0 0

/* fetch.f */
fetchPkg.sv
progCounter.sv
instrMem.sv
hazardDetect.sv
ctrlDecode.sv
fetch.sv
tbFetch.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = tbFetch
FILELIST  = fetch.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile: $(OBJDIR)/V$(TOP)

$(OBJDIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* tbFetch.sv */
`timescale 1ns/1ps
`default_nettype none

module tbFetch;
    import fetchPkg::*;

    localparam int vecFields   = 11;    // Values per cycle line
    localparam int ackLimit    = 8;     // Cycles allowed per handshake phase
    localparam int resetCycles = 3;

    logic             clk;
    logic             rstN;
    logic [wordW-1:0] imm;
    logic [wordW-1:0] rs;
    logic [wordW-1:0] brnchAddr;
    logic             pcSel;
    logic             loadReq;
    logic [wordW-1:0] loadAddr;
    logic [wordW-1:0] loadData;
    logic [wordW-1:0] pc;
    logic [wordW-1:0] instrC;
    logic [2:0]       writeRegAddr;
    logic             loadAck;
    logic             regWrite;
    logic             regJmp;
    logic             memEnable;
    logic             memWr;
    logic             val2Reg;
    logic             aluSel;
    logic [2:0]       immSel;
    logic             halt;
    logic [1:0]       linkReg;
    logic             ctrlErr;
    logic             siic;
    logic             bFlag;

    logic [wordW-1:0] stim [0:1023];    // Header, program pairs, then cycle lines
    int               nProg;
    int               nVec;
    int               cycleCnt = 0;
    int               cycleLimit = 1000;

    fetch #(.memWords(256)) UUT (
        .clk(clk), .rstN(rstN), .imm(imm), .rs(rs), .brnchAddr(brnchAddr),
        .pcSel(pcSel), .loadReq(loadReq), .loadAddr(loadAddr), .loadData(loadData),
        .pc(pc), .instrC(instrC), .writeRegAddr(writeRegAddr), .loadAck(loadAck),
        .regWrite(regWrite), .regJmp(regJmp), .memEnable(memEnable), .memWr(memWr),
        .val2Reg(val2Reg), .aluSel(aluSel), .immSel(immSel), .halt(halt),
        .linkReg(linkReg), .ctrlErr(ctrlErr), .siic(siic), .bFlag(bFlag)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycleCnt <= cycleCnt + 1;
        if (cycleCnt >= cycleLimit) begin
            $display("Timeout after %0d cycles, the stimulus never ran to its end", cycleCnt);
            $display("Test failed");
            $fatal(1);
        end
    end

    task automatic stopWithFailure(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1);
    endtask

    function automatic string testName(input logic [wordW-1:0] id);
        case (id)
            16'd1:   return "program load";
            16'd2:   return "decode";
            16'd3:   return "redirection";
            16'd4:   return "load-use";
            16'd5:   return "halt";
            default: return "unknown";
        endcase
    endfunction

    task automatic checkField(input string test, input int cyc, input string field,
                              input logic [wordW-1:0] expected,
                              input logic [wordW-1:0] actual);
        assert (actual === expected) else
            stopWithFailure($sformatf("FAILED %s, cycle %0d, %s: expected %h actual %h",
                                      test, cyc, field, expected, actual));
    endtask

    // Four-phase write, entered and left on a falling edge
    task automatic loadWord(input logic [wordW-1:0] addr, input logic [wordW-1:0] data);
        int waitCnt;
        loadAddr = addr;
        loadData = data;
        loadReq  = 1'b1;
        waitCnt  = 0;
        while (!loadAck && waitCnt < ackLimit) begin
            @(negedge clk);
            waitCnt++;
        end
        assert (loadAck) else
            stopWithFailure($sformatf("Memory gave no loadAck within %0d cycles at address %h",
                                      ackLimit, addr));
        loadReq = 1'b0;
        waitCnt = 0;
        while (loadAck && waitCnt < ackLimit) begin
            @(negedge clk);
            waitCnt++;
        end
        assert (!loadAck) else
            stopWithFailure($sformatf("loadAck stayed high after the request dropped at %h",
                                      addr));
    endtask

    task automatic pulseReset();
        rstN = 1'b0;
        repeat (resetCycles) @(negedge clk);
        rstN = 1'b1;                            // Released on a falling edge
    endtask

    initial begin
        int         base;
        string      name;
        opcodeT     expOp;
        logic [2:0] expJump;
        imm       = 16'($urandom(32'h0efa_a787));     // Seeds the generator for the run
        clk       = 1'b0;
        rstN      = 1'b0;
        rs        = '0;
        brnchAddr = '0;
        pcSel     = 1'b0;
        loadReq   = 1'b0;
        loadAddr  = '0;
        loadData  = '0;

        $readmemh("fetchInput.txt", stim);
        nProg = int'(stim[0]);
        nVec  = int'(stim[1]);
        assert (nVec > 0) else
            stopWithFailure("Stimulus file fetchInput.txt is missing or holds no cycles");
        cycleLimit = 4 * nVec + 2 * ackLimit * nProg + 4 * resetCycles;

        // Ack flop is held clear in reset, so the program goes in between two pulses
        pulseReset();
        for (int k = 0; k < nProg; k++) begin
            loadWord(stim[2 + 2 * k], stim[3 + 2 * k]);
        end
        pulseReset();

        for (int i = 0; i < nVec; i++) begin
            base      = 2 + 2 * nProg + vecFields * i;
            pcSel     = stim[base + 1][0];
            brnchAddr = stim[base + 4];
            if (pcSel) begin
                rs  = stim[base + 2];
                imm = stim[base + 3];
            end else begin
                rs  = 16'($urandom);            // Not looked at on sequential cycles
                imm = 16'($urandom);
            end
            #1;
            name = testName(stim[base]);
            checkField(name, i, "pc", stim[base + 5], pc);
            checkField(name, i, "instrC", stim[base + 6], instrC);
            checkField(name, i, "writeRegAddr", stim[base + 7], 16'(writeRegAddr));
            checkField(name, i, "halt", stim[base + 8], 16'(halt));
            checkField(name, i, "ctrlErr", stim[base + 9], 16'(ctrlErr));
            checkField(name, i, "flags", stim[base + 10],
                       16'({regWrite, memEnable, memWr, bFlag}));

            // Register jumps, SIIC and the link write of the expected word
            expOp   = opcodeT'(stim[base + 6][15:11]);
            expJump = {expOp inside {opJr, opJalr}, expOp == opSiic,
                       expOp inside {opJal, opJalr}};
            checkField(name, i, "regJmp siic link", 16'(expJump),
                       16'({regJmp, siic, |linkReg}));

            // NOP and illegal words drive nothing else
            if (stim[base + 9][0] || stim[base + 6] == nopInstr) begin
                checkField(name, i, "idle controls", 16'd0,
                           16'({val2Reg, aluSel, immSel, linkReg, regJmp, siic}));
            end
            @(negedge clk);
        end

        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

/* fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch #(
    parameter int memWords = 256
) (
    input  wire                        clk,
    input  wire                        rstN,
    input  wire  [fetchPkg::wordW-1:0] imm,
    input  wire  [fetchPkg::wordW-1:0] rs,
    input  wire  [fetchPkg::wordW-1:0] brnchAddr,
    input  wire                        pcSel,
    input  wire                        loadReq,
    input  wire  [fetchPkg::wordW-1:0] loadAddr,
    input  wire  [fetchPkg::wordW-1:0] loadData,
    output logic [fetchPkg::wordW-1:0] pc,
    output logic [fetchPkg::wordW-1:0] instrC,
    output logic [2:0]                 writeRegAddr,
    output logic                       loadAck,
    output logic                       regWrite,
    output logic                       regJmp,
    output logic                       memEnable,
    output logic                       memWr,
    output logic                       val2Reg,
    output logic                       aluSel,
    output logic [2:0]                 immSel,
    output logic                       halt,
    output logic [1:0]                 linkReg,
    output logic                       ctrlErr,
    output logic                       siic,
    output logic                       bFlag
);
    import fetchPkg::*;

    logic [wordW-1:0] instr;        // Raw word at pc
    logic [wordW-1:0] instrB;       // After bubble insertion
    opcodeT           rawOp;
    opcodeT           issueOp;
    destSelT          destSel;
    logic             srcRsUsed;
    logic             srcRtUsed;
    logic             bubble;
    logic             pcStall;
    logic             hold;

    assign hold = halt || pcStall;

    progCounter pcUnit (
        .clk(clk), .rstN(rstN), .imm(imm), .rs(rs), .brnchAddr(brnchAddr),
        .pcSel(pcSel), .regJmp(regJmp), .siic(siic), .hold(hold), .pc(pc)
    );

    instrMem #(.memWords(memWords)) iMem (
        .clk(clk), .rstN(rstN), .addr(pc), .instr(instr),
        .loadReq(loadReq), .loadAddr(loadAddr), .loadData(loadData), .loadAck(loadAck)
    );

    assign instrB  = bubble ? nopInstr : instr;
    assign instrC  = instrB;
    assign rawOp   = opcodeT'(instr[15:11]);
    assign issueOp = opcodeT'(instrB[15:11]);

    // Source use comes from the raw word, so the bubble cannot feed its own cause
    ctrlDecode peekDec (
        .opcode(rawOp), .regWrite(), .destSel(), .regJmp(), .memEnable(), .memWr(),
        .val2Reg(), .aluSel(), .immSel(), .halt(), .linkReg(), .ctrlErr(), .siic(),
        .bFlag(), .srcRsUsed(srcRsUsed), .srcRtUsed(srcRtUsed)
    );

    // Controls for the word actually issued
    ctrlDecode issueDec (
        .opcode(issueOp), .regWrite(regWrite), .destSel(destSel), .regJmp(regJmp),
        .memEnable(memEnable), .memWr(memWr), .val2Reg(val2Reg), .aluSel(aluSel),
        .immSel(immSel), .halt(halt), .linkReg(linkReg), .ctrlErr(ctrlErr),
        .siic(siic), .bFlag(bFlag), .srcRsUsed(), .srcRtUsed()
    );

    hazardDetect hdu (
        .clk(clk), .rstN(rstN), .instr(instr), .memEnable(memEnable), .memWr(memWr),
        .writeRegAddr(writeRegAddr), .srcRsUsed(srcRsUsed), .srcRtUsed(srcRtUsed),
        .bubble(bubble), .pcStall(pcStall)
    );

    // Destination register field
    always_comb begin
        case (destSel)
            destRs:  writeRegAddr = instr[10:8];
            destRdR: writeRegAddr = instr[4:2];
            destR7:  writeRegAddr = 3'd7;
            destRdI: writeRegAddr = instr[7:5];
        endcase
    end

endmodule

`default_nettype wire

/* ctrlDecode.sv */
`timescale 1ns/1ps
`default_nettype none

module ctrlDecode (
    input  wire fetchPkg::opcodeT opcode,
    output logic                  regWrite,
    output fetchPkg::destSelT     destSel,
    output logic                  regJmp,
    output logic                  memEnable,
    output logic                  memWr,
    output logic                  val2Reg,
    output logic                  aluSel,
    output logic [2:0]            immSel,
    output logic                  halt,
    output logic [1:0]            linkReg,
    output logic                  ctrlErr,
    output logic                  siic,
    output logic                  bFlag,
    output logic                  srcRsUsed,
    output logic                  srcRtUsed
);
    import fetchPkg::*;

    // Immediate extension selects for the execute stage
    localparam logic [2:0] immNone = 3'd0;
    localparam logic [2:0] immS5   = 3'd1;    // instr[4:0] sign extended
    localparam logic [2:0] immZ5   = 3'd2;    // instr[4:0] zero extended
    localparam logic [2:0] immS8   = 3'd3;    // instr[7:0] sign extended
    localparam logic [2:0] immZ8   = 3'd4;    // instr[7:0] zero extended
    localparam logic [2:0] immS11  = 3'd5;    // instr[10:0] sign extended

    always_comb begin
        // Everything inactive unless the opcode says otherwise
        regWrite  = 1'b0;
        destSel   = destRs;
        regJmp    = 1'b0;
        memEnable = 1'b0;
        memWr     = 1'b0;
        val2Reg   = 1'b0;
        aluSel    = 1'b0;
        immSel    = immNone;
        halt      = 1'b0;
        linkReg   = 2'b00;
        ctrlErr   = 1'b0;
        siic      = 1'b0;
        bFlag     = 1'b0;
        srcRsUsed = 1'b0;
        srcRtUsed = 1'b0;

        case (opcode)
            opHalt: halt = 1'b1;
            opNop: ;                            // Also the bubble word
            opSiic: siic = 1'b1;
            opJ: immSel = immS11;
            opJr: begin
                regJmp    = 1'b1;
                immSel    = immS8;
                srcRsUsed = 1'b1;
            end
            opJal: begin
                regWrite = 1'b1;
                destSel  = destR7;
                linkReg  = 2'b01;               // Write pc+2
                immSel   = immS11;
            end
            opJalr: begin
                regWrite  = 1'b1;
                destSel   = destR7;
                linkReg   = 2'b01;
                regJmp    = 1'b1;
                immSel    = immS8;
                srcRsUsed = 1'b1;
            end
            opBeqz, opBnez, opBltz, opBgez: begin
                bFlag     = 1'b1;
                immSel    = immS8;
                srcRsUsed = 1'b1;
            end
            opAddi, opSubi, opXori, opAndni: begin
                regWrite  = 1'b1;
                destSel   = destRdI;
                aluSel    = 1'b1;
                // Logical ops take an unsigned immediate
                immSel    = (opcode == opXori || opcode == opAndni) ? immZ5 : immS5;
                srcRsUsed = 1'b1;
            end
            opSt: begin
                memEnable = 1'b1;
                memWr     = 1'b1;
                aluSel    = 1'b1;
                immSel    = immS5;
                srcRsUsed = 1'b1;
                srcRtUsed = 1'b1;               // Store data in instr[7:5]
            end
            opLd: begin
                memEnable = 1'b1;
                regWrite  = 1'b1;
                destSel   = destRdI;
                val2Reg   = 1'b1;
                aluSel    = 1'b1;
                immSel    = immS5;
                srcRsUsed = 1'b1;
            end
            opStu: begin
                memEnable = 1'b1;
                memWr     = 1'b1;
                regWrite  = 1'b1;               // Updated base back into Rs
                destSel   = destRs;
                aluSel    = 1'b1;
                immSel    = immS5;
                srcRsUsed = 1'b1;
                srcRtUsed = 1'b1;
            end
            opSlbi: begin
                regWrite  = 1'b1;
                destSel   = destRs;
                aluSel    = 1'b1;
                immSel    = immZ8;
                srcRsUsed = 1'b1;
            end
            opLbi: begin
                regWrite = 1'b1;
                destSel  = destRs;
                aluSel   = 1'b1;
                immSel   = immS8;
            end
            opBtr: begin
                regWrite  = 1'b1;
                destSel   = destRdR;
                srcRsUsed = 1'b1;
            end
            opAlu, opShift, opSeq, opSlt, opSle, opSco: begin
                regWrite  = 1'b1;
                destSel   = destRdR;
                srcRsUsed = 1'b1;
                srcRtUsed = 1'b1;
            end
            default: ctrlErr = 1'b1;            // Unassigned encodings
        endcase
    end

endmodule

`default_nettype wire

/* hazardDetect.sv */
`timescale 1ns/1ps
`default_nettype none

module hazardDetect (
    input  wire                        clk,
    input  wire                        rstN,
    input  wire  [fetchPkg::wordW-1:0] instr,
    input  wire                        memEnable,
    input  wire                        memWr,
    input  wire  [2:0]                 writeRegAddr,
    input  wire                        srcRsUsed,
    input  wire                        srcRtUsed,
    output logic                       bubble,
    output logic                       pcStall
);
    logic       loadQ;          // Last issued instr was a load
    logic [2:0] loadDestQ;      // Its destination register
    logic       stallQ;         // Bubble already spent on this instr
    logic       rsHit;
    logic       rtHit;

    // Source fields of the instruction now being fetched
    assign rsHit = srcRsUsed && (instr[10:8] == loadDestQ);
    assign rtHit = srcRtUsed && (instr[7:5] == loadDestQ);

    // One bubble per dependent instruction
    assign bubble  = loadQ && !stallQ && (rsHit || rtHit);
    assign pcStall = bubble;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            loadQ  <= 1'b0;
            stallQ <= 1'b0;
        end else begin
            stallQ <= bubble;
            // A bubble leaves the load record alone
            if (!bubble) begin
                loadQ <= memEnable && !memWr;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!bubble) begin
            loadDestQ <= writeRegAddr;
        end
    end

endmodule

`default_nettype wire

/* instrMem.sv */
`timescale 1ns/1ps
`default_nettype none

module instrMem #(
    parameter int memWords = 256
) (
    input  wire                        clk,
    input  wire                        rstN,
    input  wire  [fetchPkg::wordW-1:0] addr,
    output logic [fetchPkg::wordW-1:0] instr,
    input  wire                        loadReq,
    input  wire  [fetchPkg::wordW-1:0] loadAddr,
    input  wire  [fetchPkg::wordW-1:0] loadData,
    output logic                       loadAck
);
    import fetchPkg::*;

    // Word index width, memWords is a power of two
    localparam int idxW = $clog2(memWords);

    logic [wordW-1:0] mem [memWords];
    logic [idxW-1:0]  rdIdx;
    logic [idxW-1:0]  wrIdx;
    logic             wrEn;

    // Both addresses are byte addresses like pc
    // Bit 0 is dropped and the upper bits wrap around
    assign rdIdx = addr[idxW:1];
    assign wrIdx = loadAddr[idxW:1];

    // Asynchronous read port for fetch
    assign instr = mem[rdIdx];

    // First cycle of a request that has not been acked yet
    assign wrEn = loadReq && !loadAck;

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrIdx] <= loadData;     // Same edge that raises loadAck
        end
    end

    // Four-phase ack, follows loadReq by one cycle in both directions
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            loadAck <= 1'b0;
        end else if (wrEn) begin
            loadAck <= 1'b1;
        end else if (!loadReq) begin
            loadAck <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* progCounter.sv */
`timescale 1ns/1ps
`default_nettype none

module progCounter (
    input  wire                        clk,
    input  wire                        rstN,
    input  wire  [fetchPkg::wordW-1:0] imm,
    input  wire  [fetchPkg::wordW-1:0] rs,
    input  wire  [fetchPkg::wordW-1:0] brnchAddr,
    input  wire                        pcSel,
    input  wire                        regJmp,
    input  wire                        siic,
    input  wire                        hold,
    output logic [fetchPkg::wordW-1:0] pc
);
    import fetchPkg::*;

    logic [wordW-1:0] pcNext;

    // Hold wins, then SIIC, then a taken redirect, then sequential
    always_comb begin
        if (hold) begin
            pcNext = pc;
        end else if (siic) begin
            pcNext = siicVector;
        end else if (pcSel) begin
            if (regJmp) begin
                pcNext = rs + imm;      // JR and JALR
            end else begin
                pcNext = brnchAddr;
            end
        end else begin
            pcNext = pc + 16'd2;        // Byte addressed, one word per step
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end

endmodule

`default_nettype wire

/* fetchPkg.sv */
`default_nettype none

package fetchPkg;

    // Data and instruction width
    localparam int wordW = 16;

    // Major opcode, instr[15:11]
    typedef enum logic [4:0] {
        opHalt   = 5'b00000,
        opNop    = 5'b00001,
        opSiic   = 5'b00010,

        // Jumps
        opJ      = 5'b00100,
        opJr     = 5'b00101,
        opJal    = 5'b00110,
        opJalr   = 5'b00111,

        // Immediate arithmetic, I-format 1
        opAddi   = 5'b01000,
        opSubi   = 5'b01001,
        opXori   = 5'b01010,
        opAndni  = 5'b01011,

        // Branches compare Rs against zero
        opBeqz   = 5'b01100,
        opBnez   = 5'b01101,
        opBltz   = 5'b01110,
        opBgez   = 5'b01111,

        // Memory
        opSt     = 5'b10000,
        opLd     = 5'b10001,
        opSlbi   = 5'b10010,
        opStu    = 5'b10011,

        opLbi    = 5'b11000,
        opBtr    = 5'b11001,

        // R-format, function in instr[1:0]
        opShift  = 5'b11010,
        opAlu    = 5'b11011,
        opSeq    = 5'b11100,
        opSlt    = 5'b11101,
        opSle    = 5'b11110,
        opSco    = 5'b11111
    } opcodeT;

    // Where the destination register number comes from
    typedef enum logic [1:0] {
        destRs  = 2'b00,    // instr[10:8]
        destRdR = 2'b01,    // instr[4:2]
        destR7  = 2'b10,    // Link register
        destRdI = 2'b11     // instr[7:5]
    } destSelT;

    // Bubble word, opcode opNop with all fields zero
    localparam logic [wordW-1:0] nopInstr = 16'h0800;

    // Exception entry point
    localparam logic [wordW-1:0] siicVector = 16'h0002;

endpackage

`default_nettype wire
